//--- design/link_counter.sv
`timescale 1ns/1ns

module link_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              cnt_clr,
    input  logic              cnt_inc,
    input  rfb_pkg::pkt_idx_t cnt_limit,
    output rfb_pkg::pkt_idx_t count,
    output logic              cnt_done
);

    // Clear wins over increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (cnt_clr) begin
            count <= '0;
        end else if (cnt_inc) begin
            count <= count + 1'b1;
        end
    end

    assign cnt_done = (count == cnt_limit);

endmodule

//--- design/link_ctrl_fsm.sv
`timescale 1ns/1ns

module link_ctrl_fsm #(
    parameter int PKT_BYTES = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_mode,
    input  logic              pkt_done,
    input  logic              bit_tick,
    input  logic              xfer_start,
    input  logic              xfer_end,
    input  rfb_pkg::pkt_idx_t count,
    input  logic              cnt_done,
    output logic              pkt_load,
    output logic              spi_load,
    output rfb_pkg::pkt_idx_t byte_idx,
    output logic              ser_load,
    output logic              ser_shift,
    output logic              cnt_clr,
    output logic              cnt_inc,
    output rfb_pkg::pkt_idx_t cnt_limit,
    output logic              pkt_ready,
    output logic              tx_busy
);

    localparam rfb_pkg::pkt_idx_t LAST_BYTE = rfb_pkg::pkt_idx_t'(PKT_BYTES - 1);
    localparam rfb_pkg::pkt_idx_t TX_BITS   = 4'd8;

    rfb_pkg::rx_state_e rx_state;
    rfb_pkg::tx_state_e tx_state;
    logic               rx_inc;
    logic               tx_inc;

    // Receive side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_state <= rfb_pkg::WAIT_PKT;
        end else begin
            case (rx_state)
                rfb_pkg::WAIT_PKT: begin
                    // Packets that finish in any other state are dropped
                    if (rx_mode && pkt_done) begin
                        rx_state <= rfb_pkg::LOAD_PKT;
                    end
                end
                rfb_pkg::LOAD_PKT: begin
                    rx_state <= rfb_pkg::SERVE;
                end
                rfb_pkg::SERVE: begin
                    if (xfer_start) begin
                        rx_state <= rfb_pkg::XFER;
                    end
                end
                rfb_pkg::XFER: begin
                    if (xfer_end) begin
                        if (count == LAST_BYTE) begin
                            rx_state <= rfb_pkg::WAIT_PKT;
                        end else begin
                            rx_state <= rfb_pkg::SERVE;
                        end
                    end
                end
                default: rx_state <= rfb_pkg::WAIT_PKT;
            endcase
        end
    end

    // Transmit side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_state <= rfb_pkg::TX_IDLE;
        end else begin
            case (tx_state)
                rfb_pkg::TX_IDLE: begin
                    if (!rx_mode && xfer_end) begin
                        tx_state <= rfb_pkg::TX_CAPTURE;
                    end
                end
                // rx_byte is valid one cycle after xfer_end
                rfb_pkg::TX_CAPTURE: begin
                    tx_state <= rfb_pkg::TX_SEND;
                end
                rfb_pkg::TX_SEND: begin
                    if (cnt_done) begin
                        tx_state <= rfb_pkg::TX_IDLE;
                    end
                end
                default: tx_state <= rfb_pkg::TX_IDLE;
            endcase
        end
    end

    assign pkt_load = (rx_state == rfb_pkg::LOAD_PKT);
    assign spi_load = (rx_state == rfb_pkg::SERVE);
    assign byte_idx = count;

    assign ser_load  = (tx_state == rfb_pkg::TX_CAPTURE);
    assign ser_shift = tx_inc;

    // One counter, shared by the two directions
    assign rx_inc    = (rx_state == rfb_pkg::XFER) && xfer_end;
    assign tx_inc    = (tx_state == rfb_pkg::TX_SEND) && bit_tick && !cnt_done;
    assign cnt_clr   = pkt_load | ser_load;
    assign cnt_inc   = rx_inc | tx_inc;
    assign cnt_limit = rx_mode ? rfb_pkg::pkt_idx_t'(PKT_BYTES) : TX_BITS;

    assign pkt_ready = (rx_state == rfb_pkg::SERVE) || (rx_state == rfb_pkg::XFER);
    assign tx_busy   = (tx_state == rfb_pkg::TX_SEND);

endmodule

//--- design/pkt_reg.sv
`timescale 1ns/1ns

module pkt_reg #(
    parameter int PKT_BYTES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pkt_load,
    input  logic [PKT_BYTES*8-1:0] pkt_data,
    input  rfb_pkg::pkt_idx_t      byte_idx,
    output rfb_pkg::byte_t         rd_byte
);

    // Element PKT_BYTES-1 holds the first received byte
    rfb_pkg::byte_t [PKT_BYTES-1:0] pkt_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pkt_q <= '0;
        end else if (pkt_load) begin
            pkt_q <= pkt_data;
        end
    end

    // Index past the end reads as zero
    always_comb begin
        if (int'(byte_idx) < PKT_BYTES) begin
            rd_byte = pkt_q[PKT_BYTES - 1 - int'(byte_idx)];
        end else begin
            rd_byte = '0;
        end
    end

endmodule

//--- design/rf_rx_shifter.sv
`timescale 1ns/1ns
`include "rfb_defs.svh"

module rf_rx_shifter #(
    parameter int PKT_BYTES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rf_in,
    input  logic                   rf_strobe,
    output logic                   bit_tick,
    output logic                   pkt_done,
    output logic [PKT_BYTES*8-1:0] pkt_data
);

    localparam int PKT_BITS = PKT_BYTES * 8;
    localparam int CNT_W = $clog2(PKT_BITS);

    logic [`SCK_SYNC_STAGES-1:0] strobe_sync;
    logic [`SCK_SYNC_STAGES-1:0] data_sync;
    logic                        strobe_q;
    logic [CNT_W-1:0]            bit_cnt;
    logic [PKT_BITS-1:0]         shift_q;

    // Rising edge of the synchronized strobe
    assign bit_tick = strobe_sync[`SCK_SYNC_STAGES-1] & ~strobe_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobe_sync <= '0;
            data_sync   <= '0;
            strobe_q    <= 1'b0;
            bit_cnt     <= '0;
            pkt_done    <= 1'b0;
        end else begin
            strobe_sync <= {strobe_sync[`SCK_SYNC_STAGES-2:0], rf_strobe};
            data_sync   <= {data_sync[`SCK_SYNC_STAGES-2:0], rf_in};
            strobe_q    <= strobe_sync[`SCK_SYNC_STAGES-1];
            pkt_done    <= bit_tick && (bit_cnt == CNT_W'(PKT_BITS - 1));
            if (bit_tick) begin
                // Framing runs freely from reset, one packet every PKT_BITS bits
                if (bit_cnt == CNT_W'(PKT_BITS - 1)) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // MSB first, so the first byte ends up in the top bits
    always_ff @(posedge clk) begin
        if (bit_tick) begin
            shift_q <= {shift_q[PKT_BITS-2:0], data_sync[`SCK_SYNC_STAGES-1]};
        end
    end

    assign pkt_data = shift_q;

endmodule

//--- design/rf_spi_bridge.sv
`timescale 1ns/1ns

module rf_spi_bridge #(
    parameter int PKT_BYTES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic rx_mode,
    input  logic rf_in,
    input  logic rf_strobe,
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic tx_out,
    output logic tx_busy,
    output logic pkt_ready
);

    logic [PKT_BYTES*8-1:0] pkt_data;
    logic                   pkt_done;
    logic                   bit_tick;
    logic                   pkt_load;
    logic                   spi_load;
    logic                   ser_load;
    logic                   ser_shift;
    logic                   cnt_clr;
    logic                   cnt_inc;
    logic                   cnt_done;
    logic                   xfer_start;
    logic                   xfer_end;
    rfb_pkg::pkt_idx_t      byte_idx;
    rfb_pkg::pkt_idx_t      count;
    rfb_pkg::pkt_idx_t      cnt_limit;
    rfb_pkg::byte_t         rd_byte;
    rfb_pkg::byte_t         rx_byte;

    // Byte index and counter are only four bits wide
    if (PKT_BYTES < 1 || PKT_BYTES > rfb_pkg::MAX_PKT_BYTES) begin : g_bad_size
        $error("PKT_BYTES out of range");
    end

    rf_rx_shifter #(.PKT_BYTES(PKT_BYTES)) rf_rx_shifter_inst (
        .clk       (clk),
        .rst       (rst),
        .rf_in     (rf_in),
        .rf_strobe (rf_strobe),
        .bit_tick  (bit_tick),
        .pkt_done  (pkt_done),
        .pkt_data  (pkt_data)
    );

    pkt_reg #(.PKT_BYTES(PKT_BYTES)) pkt_reg_inst (
        .clk      (clk),
        .rst      (rst),
        .pkt_load (pkt_load),
        .pkt_data (pkt_data),
        .byte_idx (byte_idx),
        .rd_byte  (rd_byte)
    );

    spi_slave spi_slave_inst (
        .clk        (clk),
        .rst        (rst),
        .sck        (sck),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .spi_load   (spi_load),
        .tx_byte    (rd_byte),
        .miso       (miso),
        .rx_byte    (rx_byte),
        .xfer_start (xfer_start),
        .xfer_end   (xfer_end)
    );

    tx_serializer tx_serializer_inst (
        .clk       (clk),
        .rst       (rst),
        .ser_load  (ser_load),
        .ser_shift (ser_shift),
        .din       (rx_byte),
        .tx_out    (tx_out)
    );

    link_counter link_counter_inst (
        .clk       (clk),
        .rst       (rst),
        .cnt_clr   (cnt_clr),
        .cnt_inc   (cnt_inc),
        .cnt_limit (cnt_limit),
        .count     (count),
        .cnt_done  (cnt_done)
    );

    link_ctrl_fsm #(.PKT_BYTES(PKT_BYTES)) link_ctrl_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .rx_mode    (rx_mode),
        .pkt_done   (pkt_done),
        .bit_tick   (bit_tick),
        .xfer_start (xfer_start),
        .xfer_end   (xfer_end),
        .count      (count),
        .cnt_done   (cnt_done),
        .pkt_load   (pkt_load),
        .spi_load   (spi_load),
        .byte_idx   (byte_idx),
        .ser_load   (ser_load),
        .ser_shift  (ser_shift),
        .cnt_clr    (cnt_clr),
        .cnt_inc    (cnt_inc),
        .cnt_limit  (cnt_limit),
        .pkt_ready  (pkt_ready),
        .tx_busy    (tx_busy)
    );

endmodule

//--- design/rfb_pkg.sv
package rfb_pkg;

    // One data byte on SPI or on the radio side
    typedef logic [7:0] byte_t;

    // Byte index within a packet, or a count of transmit bits
    typedef logic [3:0] pkt_idx_t;

    // Largest packet that pkt_idx_t can still address
    localparam int MAX_PKT_BYTES = 15;

    typedef enum logic [1:0] {
        WAIT_PKT,
        LOAD_PKT,
        SERVE,
        XFER
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_CAPTURE,
        TX_SEND
    } tx_state_e;

endpackage

//--- design/spi_slave.sv
`timescale 1ns/1ns
`include "rfb_defs.svh"

module spi_slave (
    input  logic           clk,
    input  logic           rst,
    input  logic           sck,
    input  logic           cs_n,
    input  logic           mosi,
    input  logic           spi_load,
    input  rfb_pkg::byte_t tx_byte,
    output logic           miso,
    output rfb_pkg::byte_t rx_byte,
    output logic           xfer_start,
    output logic           xfer_end
);

    logic [`SCK_SYNC_STAGES-1:0] sck_sync;
    logic [`SCK_SYNC_STAGES-1:0] cs_sync;
    logic                        sck_q;
    logic                        cs_q;
    logic                        sck_s;
    logic                        cs_s;
    logic                        sck_rise;
    logic                        sck_fall;
    rfb_pkg::byte_t              tx_sr;
    rfb_pkg::byte_t              rx_sr;

    assign sck_s = sck_sync[`SCK_SYNC_STAGES-1];
    assign cs_s  = cs_sync[`SCK_SYNC_STAGES-1];

    assign sck_rise   = sck_s & ~sck_q;
    assign sck_fall   = ~sck_s & sck_q;
    assign xfer_start = cs_q & ~cs_s;
    assign xfer_end   = ~cs_q & cs_s;

    // Chip select idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sck_sync <= '0;
            cs_sync  <= '1;
            sck_q    <= 1'b0;
            cs_q     <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[`SCK_SYNC_STAGES-2:0], sck};
            cs_sync  <= {cs_sync[`SCK_SYNC_STAGES-2:0], cs_n};
            sck_q    <= sck_s;
            cs_q     <= cs_s;
        end
    end

    // Mode 0, so the next bit goes out after each falling edge of sck
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_sr <= '0;
        end else if (spi_load) begin
            tx_sr <= tx_byte;
        end else if (sck_fall && !cs_s) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
    end

    // mosi is stable for the whole high phase of sck
    always_ff @(posedge clk) begin
        if (sck_rise && !cs_s) begin
            rx_sr <= {rx_sr[6:0], mosi};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_byte <= '0;
        end else if (xfer_end) begin
            rx_byte <= rx_sr;
        end
    end

    // Raw cs_n so the MSB shows up at once when cs_n falls
    assign miso = ~cs_n & tx_sr[7];

endmodule

//--- design/tx_serializer.sv
`timescale 1ns/1ns

module tx_serializer (
    input  logic           clk,
    input  logic           rst,
    input  logic           ser_load,
    input  logic           ser_shift,
    input  rfb_pkg::byte_t din,
    output logic           tx_out
);

    rfb_pkg::byte_t sr;

    // Zeros shift in behind the data, so the line is back to 0 after eight shifts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr <= '0;
        end else if (ser_load) begin
            sr <= din;
        end else if (ser_shift) begin
            sr <= {sr[6:0], 1'b0};
        end
    end

    assign tx_out = sr[7];

endmodule

//--- dv/rf_spi_bridge_checker.sv
`timescale 1ns/1ns

module rf_spi_bridge_checker (
    input logic clk,
    input logic rst,
    input logic cs_n,
    input logic miso,
    input logic tx_out,
    input logic tx_busy,
    input logic pkt_ready
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // Only one direction may be active
    a_one_direction: assert property (@(posedge clk) disable iff (rst)
        !(pkt_ready && tx_busy))
    else begin
        fail_count++;
        $error("pkt_ready and tx_busy are high together");
    end

    a_tx_idle_low: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> !tx_out)
    else begin
        fail_count++;
        $error("tx_out is high while tx_busy is low");
    end

    a_miso_idle_low: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> !miso)
    else begin
        fail_count++;
        $error("miso is high while cs_n is high");
    end

    a_reset_outputs: assert property (@(posedge clk)
        rst |=> (!pkt_ready && !tx_busy && !tx_out && !miso))
    else begin
        fail_count++;
        $error("an output is high in the cycle after reset");
    end

endmodule

bind rf_spi_bridge rf_spi_bridge_checker rf_spi_bridge_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .cs_n      (cs_n),
    .miso      (miso),
    .tx_out    (tx_out),
    .tx_busy   (tx_busy),
    .pkt_ready (pkt_ready)
);

//--- dv/rf_spi_bridge_tb.sv
`timescale 1ns/1ns

module rf_spi_bridge_tb;

    localparam int PKT_BYTES  = 8;
    localparam int PKT_BITS   = PKT_BYTES * 8;
    localparam int STROBE_GAP = 10;
    localparam int SCK_HALF   = 6;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic rst;
    logic rx_mode;
    logic rf_in;
    logic rf_strobe;
    logic sck;
    logic cs_n;
    logic mosi;
    logic miso;
    logic tx_out;
    logic tx_busy;
    logic pkt_ready;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     total_errors;

    // Reference model of the receive path
    logic [PKT_BITS-1:0] model_shift;
    int                  model_bits;
    int                  model_reads;
    logic                model_pending;
    rfb_pkg::byte_t      exp_q[$];

    rf_spi_bridge #(.PKT_BYTES(PKT_BYTES)) rf_spi_bridge_inst (
        .clk       (clk),
        .rst       (rst),
        .rx_mode   (rx_mode),
        .rf_in     (rf_in),
        .rf_strobe (rf_strobe),
        .sck       (sck),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .tx_out    (tx_out),
        .tx_busy   (tx_busy),
        .pkt_ready (pkt_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s did not reach the expected level in time", what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wait_pkt_ready(input logic level);
        int n;
        n = 0;
        while (pkt_ready !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (pkt_ready !== level) begin
            abort_on_timeout("pkt_ready");
        end
    endtask

    task automatic wait_tx_busy(input logic level);
        int n;
        n = 0;
        while (tx_busy !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (tx_busy !== level) begin
            abort_on_timeout("tx_busy");
        end
    endtask

    // One radio bit; tx_out is sampled just before the strobe
    task automatic send_bit(input logic b, output logic line_now);
        int i;
        line_now  = tx_out;
        rf_in     = b;
        rf_strobe = 1'b1;
        next_cycle();
        rf_strobe = 1'b0;
        wait_cycles(STROBE_GAP - 1);
        model_shift = {model_shift[PKT_BITS-2:0], b};
        model_bits++;
        if (model_bits == PKT_BITS) begin
            model_bits = 0;
            // Kept only when the bridge is in receive mode with nothing pending
            if (rx_mode && !model_pending) begin
                for (i = PKT_BYTES - 1; i >= 0; i--) begin
                    exp_q.push_back(model_shift[i*8 +: 8]);
                end
                model_pending = 1'b1;
            end
        end
    endtask

    // Runs up to the next packet boundary of the free-running framing
    task automatic send_packet();
        logic [31:0] r;
        logic        unused_line;
        int          n;
        for (n = PKT_BITS - model_bits; n > 0; n--) begin
            r = $random(seed);
            send_bit(r[0], unused_line);
        end
    endtask

    task automatic spi_transfer(input rfb_pkg::byte_t out_byte,
                                output rfb_pkg::byte_t in_byte);
        int i;
        cs_n = 1'b0;
        for (i = 7; i >= 0; i--) begin
            mosi = out_byte[i];
            wait_cycles(SCK_HALF);
            in_byte[i] = miso;
            sck = 1'b1;
            wait_cycles(SCK_HALF);
            sck = 1'b0;
        end
        wait_cycles(SCK_HALF);
        cs_n = 1'b1;
        mosi = 1'b0;
        wait_cycles(SCK_HALF);
    endtask

    task automatic read_bytes(input int n);
        rfb_pkg::byte_t got;
        rfb_pkg::byte_t expected;
        logic [31:0]    r;
        int             k;
        for (k = 0; k < n; k++) begin
            r = $random(seed);
            spi_transfer(r[7:0], got);
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: a byte was read but the model holds no packet",
                         $time);
            end else begin
                expected = exp_q.pop_front();
                check_equal(got, expected, "received byte");
            end
            model_reads++;
            if (model_reads == PKT_BYTES) begin
                model_reads   = 0;
                model_pending = 1'b0;
            end
        end
    endtask

    task automatic run_receive();
        rx_mode = 1'b1;
        wait_cycles(2);
        send_packet();
        wait_pkt_ready(1'b1);
        read_bytes(PKT_BYTES);
        check_equal(pkt_ready, 1'b0, "pkt_ready after last read");
    endtask

    task automatic run_transmit();
        rfb_pkg::byte_t tx_model;
        rfb_pkg::byte_t unused_rx;
        logic [31:0]    r;
        logic           line_now;
        int             i;
        rx_mode = 1'b0;
        wait_cycles(2);
        r = $random(seed);
        tx_model = r[7:0];
        spi_transfer(tx_model, unused_rx);
        wait_tx_busy(1'b1);
        for (i = 7; i >= 0; i--) begin
            check_equal(tx_busy, 1'b1, "tx_busy during send");
            r = $random(seed);
            send_bit(r[0], line_now);
            check_equal(line_now, tx_model[i], "tx_out bit");
        end
        wait_tx_busy(1'b0);
        check_equal(tx_out, 1'b0, "tx_out after send");
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errors - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        int round;
        seed          = 32'h2c991d0d;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        model_shift   = '0;
        model_bits    = 0;
        model_reads   = 0;
        model_pending = 1'b0;
        rst       = 1'b1;
        rx_mode   = 1'b1;
        rf_in     = 1'b0;
        rf_strobe = 1'b0;
        sck       = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;

        errors_before = errors;
        check_equal(pkt_ready, 1'b0, "pkt_ready after reset");
        check_equal(tx_busy, 1'b0, "tx_busy after reset");
        check_equal(tx_out, 1'b0, "tx_out after reset");
        check_equal(miso, 1'b0, "miso after reset");
        report_test(1, "reset values", errors_before);

        errors_before = errors;
        run_receive();
        report_test(2, "single packet receive", errors_before);

        // Second packet arrives halfway through the read and must be dropped
        errors_before = errors;
        send_packet();
        wait_pkt_ready(1'b1);
        read_bytes(PKT_BYTES / 2);
        send_packet();
        check_equal(pkt_ready, 1'b1, "pkt_ready while packet is dropped");
        read_bytes(PKT_BYTES - PKT_BYTES / 2);
        check_equal(pkt_ready, 1'b0, "pkt_ready after first packet");
        run_receive();
        report_test(3, "packet dropped while busy", errors_before);

        errors_before = errors;
        run_transmit();
        report_test(4, "single byte transmit", errors_before);

        errors_before = errors;
        for (round = 0; round < 20; round++) begin
            if (round % 2 == 0) begin
                run_receive();
            end else begin
                run_transmit();
            end
        end
        report_test(5, "random rounds", errors_before);

        total_errors = errors + rf_spi_bridge_inst.rf_spi_bridge_checker_inst.fail_count;
        $display("Tests: %0d, checks: %0d, check errors: %0d, assertion errors: %0d",
                 tests, checks, errors,
                 rf_spi_bridge_inst.rf_spi_bridge_checker_inst.fail_count);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- include/rfb_defs.svh
`ifndef RFB_DEFS_SVH
`define RFB_DEFS_SVH

// Flop depth of the input synchronizers for sck, cs_n and the radio lines
`define SCK_SYNC_STAGES 2

`endif

//--- project.f
+incdir+include
design/rfb_pkg.sv
design/rf_rx_shifter.sv
design/pkt_reg.sv
design/spi_slave.sv
design/tx_serializer.sv
design/link_counter.sv
design/link_ctrl_fsm.sv
design/rf_spi_bridge.sv
dv/rf_spi_bridge_checker.sv
dv/rf_spi_bridge_tb.sv
